// File: little_computer.f
little_computer_pkg.sv
uart_rx.sv
uart_word_assembler.sv
program_loader.sv
memory_map.sv
tiny_cpu.sv
hex_display.sv
little_computer.sv
little_computer_checker.sv
little_computer_monitor.sv
tb_little_computer.sv

// File: Bender.yml
package:
  name: little_computer

sources:
  - little_computer_pkg.sv
  - uart_rx.sv
  - uart_word_assembler.sv
  - program_loader.sv
  - memory_map.sv
  - tiny_cpu.sv
  - hex_display.sv
  - little_computer.sv
  - target: test
    files:
      - little_computer_checker.sv
      - little_computer_monitor.sv
      - tb_little_computer.sv

// File: tb_little_computer.sv
`timescale 1ns/1ps

module tb_little_computer import little_computer_pkg::*; ();

    localparam int num_tests = 4;

    // One program per entry, word 0 in the top bits of prog
    typedef struct packed {
        logic [127:0] prog;
        logic [3:0]   n_words;
        led_t         exp_leds;
        word_addr_t   exp_pc;
        logic         bad_stop;
    } test_entry_t;

    logic                    sysclk;
    logic                    sysrst;
    logic                    rx;
    logic                    load_en;
    logic                    debug_mode;
    logic [8*num_digits-1:0] hex;
    led_t                    leds;
    logic                    halted;
    test_entry_t             tests [num_tests];
    integer                  seed;
    int                      cycles = 0;
    int                      cycle_limit = 0;

    little_computer little_computer_i (
        .sysclk     (sysclk),
        .sysrst     (sysrst),
        .rx         (rx),
        .load_en    (load_en),
        .debug_mode (debug_mode),
        .hex        (hex),
        .leds       (leds),
        .halted     (halted)
    );

    little_computer_monitor monitor_i (
        .hex    (hex),
        .leds   (leds),
        .halted (halted)
    );

    bind little_computer little_computer_checker checker_i (
        .sysclk     (sysclk),
        .sysrst     (sysrst),
        .load_en    (load_en),
        .halted     (halted),
        .cpu_wr_en  (cpu_wr.en),
        .word_valid (word_valid)
    );

    initial sysclk = 1'b0;
    always #10 sysclk = ~sysclk;

    always @(posedge sysclk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic test_entry_t make_test(input logic [127:0] prog, input int n,
                                              input led_t exp_leds, input word_addr_t exp_pc,
                                              input logic bad_stop);
        test_entry_t t;
        t.prog     = prog;
        t.n_words  = 4'(n);
        t.exp_leds = exp_leds;
        t.exp_pc   = exp_pc;
        t.bad_stop = bad_stop;
        return t;
    endfunction

    function automatic word_t word_at(input test_entry_t t, input int idx);
        return t.prog[127 - 16*idx -: 16];
    endfunction

    // Two frames of ten bits per word plus room to run, then doubled
    function automatic int compute_cycle_limit();
        int total;
        total = 0;
        for (int i = 0; i < num_tests; i++) begin
            total += tests[i].n_words * 2 * 160 + 200;
        end
        return total * 2;
    endfunction

    // 8N1 frame, LSB first, then a random idle gap
    task automatic send_frame(input byte_t data, input logic stop_bit);
        int gap;
        rx = 1'b0;
        repeat (clks_per_bit) @(negedge sysclk);
        for (int b = 0; b < 8; b++) begin
            rx = data[b];
            repeat (clks_per_bit) @(negedge sysclk);
        end
        rx = stop_bit;
        repeat (clks_per_bit) @(negedge sysclk);
        rx = 1'b1;
        gap = 4 + ({$random(seed)} % 8);
        repeat (gap) @(negedge sysclk);
    endtask

    task automatic check_reset(input string name);
        monitor_i.start_test();
        monitor_i.leds_match(led_t'(0));
        monitor_i.halt_state_is(1'b0);
        monitor_i.hex_matches("reset", 24'h0);
        monitor_i.finish_test(name);
    endtask

    task automatic run_program(input int idx);
        test_entry_t t;
        word_t       w;
        byte_t       pad;
        t = tests[idx];
        monitor_i.start_test();
        load_en    = 1'b1;
        debug_mode = 1'b0;
        @(negedge sysclk);
        monitor_i.hex_matches("count after reload", 24'h0);
        for (int i = 0; i < t.n_words; i++) begin
            w = word_at(t, i);
            send_frame(w[15:8], 1'b1);
            // Dropped frame between the halves of word 1
            if (t.bad_stop && i == 1) begin
                pad = byte_t'($random(seed));
                send_frame(pad, 1'b0);
            end
            send_frame(w[7:0], 1'b1);
        end
        monitor_i.hex_matches("load count", 24'(t.n_words));
        load_en = 1'b0;
        while (!halted) @(negedge sysclk);
        monitor_i.leds_match(t.exp_leds);
        monitor_i.hex_matches("led value", 24'(t.exp_leds));
        debug_mode = 1'b1;
        @(negedge sysclk);
        monitor_i.hex_matches("debug view", {word_at(t, t.exp_pc - 1), t.exp_pc});
        // HALTED holds until the next reset
        monitor_i.halt_state_is(1'b1);
        debug_mode = 1'b0;
        monitor_i.finish_test($sformatf("program %0d", idx));
    endtask

    initial begin
        int assert_failures;
        seed       = 32'hb652;
        sysrst     = 1'b0;
        rx         = 1'b1;
        load_en    = 1'b0;
        debug_mode = 1'b0;
        // LDI, ADD, SW to LED, LW back, BEQZ, HALT
        tests[0] = make_test({16'h1025, 16'h141A, 16'h2100, 16'h18FF,
                              16'h4200, 16'h3E00, 16'h6C06, 16'hF000}, 8, 10'h03F, 8'h08, 1'b0);
        // JMP over a clearing LDI
        tests[1] = make_test({16'h1055, 16'h5003, 16'h1000, 16'h1CFF,
                              16'h2000, 16'h4300, 16'hF000, 16'h0000}, 7, 10'h0AA, 8'h07, 1'b1);
        // Taken BEQZ skips the first HALT
        tests[2] = make_test({16'h14FF, 16'h2500, 16'h2500, 16'h1CFF,
                              16'h6806, 16'hF000, 16'h4700, 16'hF000}, 8, 10'h3FC, 8'h08, 1'b0);
        // LW of a data word, unused opcode runs as NOP
        tests[3] = make_test({16'h1806, 16'h3200, 16'h1CFF, 16'h7123,
                              16'h4300, 16'hF000, 16'h0123, 16'h0000}, 7, 10'h123, 8'h06, 1'b1);
        cycle_limit = compute_cycle_limit();

        repeat (8) @(negedge sysclk);
        check_reset("reset at start");
        sysrst = 1'b1;
        @(negedge sysclk);
        for (int i = 0; i < num_tests; i++) begin
            run_program(i);
        end

        sysrst = 1'b0;
        repeat (8) @(negedge sysclk);
        check_reset("reset after run");
        sysrst = 1'b1;
        @(negedge sysclk);

        assert_failures = little_computer_i.checker_i.failures;
        $display("Done: %0d tests passed, %0d tests failed, %0d assertion failures",
                 monitor_i.tests_passed, monitor_i.tests_failed, assert_failures);
        if (monitor_i.tests_failed == 0 && assert_failures == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: little_computer_monitor.sv
`timescale 1ns/1ps

module little_computer_monitor import little_computer_pkg::*; (
    input logic                    [8*num_digits-1:0] hex,
    input led_t                    leds,
    input logic                    halted
);

    int test_errors  = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    // Digit 0 on the right, one seg_encode pattern per nibble
    function automatic logic [8*num_digits-1:0] digits_for(input logic [4*num_digits-1:0] value);
        logic [8*num_digits-1:0] seg;
        for (int i = 0; i < num_digits; i++) begin
            seg[8*i +: 8] = seg_encode(value[4*i +: 4]);
        end
        return seg;
    endfunction

    task automatic start_test();
        test_errors = 0;
    endtask

    task automatic hex_matches(input string what, input logic [4*num_digits-1:0] value);
        logic [8*num_digits-1:0] expected;
        expected = digits_for(value);
        if (hex !== expected) begin
            test_errors++;
            $display("[ERROR] %0d ns hex (%s): got %h, expected %h",
                     $time, what, hex, expected);
        end
    endtask

    task automatic leds_match(input led_t expected);
        if (leds !== expected) begin
            test_errors++;
            $display("[ERROR] %0d ns leds: got %h, expected %h", $time, leds, expected);
        end
    endtask

    task automatic halt_state_is(input logic expected);
        if (halted !== expected) begin
            test_errors++;
            $display("[ERROR] %0d ns halted: got %b, expected %b", $time, halted, expected);
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("PASS  %s", name);
        end else begin
            tests_failed++;
            $display("FAIL  %s, %0d mismatches", name, test_errors);
        end
    endtask

endmodule

// File: little_computer_checker.sv
`timescale 1ns/1ps

module little_computer_checker (
    input logic sysclk,
    input logic sysrst,
    input logic load_en,
    input logic halted,
    input logic cpu_wr_en,
    input logic word_valid
);

    int failures = 0;

    // CPU reset is synchronous, so halted clears one edge into a load
    halt_clear_in_load: assert property (@(posedge sysclk) disable iff (!sysrst)
        load_en && $past(load_en) |-> !halted)
        else begin
            failures++;
            $error("halted is high during a program load");
        end

    no_cpu_store_in_load: assert property (@(posedge sysclk) disable iff (!sysrst)
        load_en |-> !cpu_wr_en)
        else begin
            failures++;
            $error("CPU write enable is high during a program load");
        end

    word_pulse_single: assert property (@(posedge sysclk) disable iff (!sysrst)
        word_valid |=> !word_valid)
        else begin
            failures++;
            $error("word_valid is high for more than one cycle");
        end

endmodule

// File: little_computer.sv
`timescale 1ns/1ps

module little_computer import little_computer_pkg::*; (
    input  logic                    sysclk,
    input  logic                    sysrst,
    input  logic                    rx,
    input  logic                    load_en,
    input  logic                    debug_mode,
    output logic [8*num_digits-1:0] hex,
    output led_t                    leds,
    output logic                    halted
);

    logic       byte_valid;
    byte_t      byte_data;
    logic       word_valid;
    word_t      word_data;
    mem_wr_t    load_wr;
    mem_wr_t    cpu_wr;
    mem_wr_t    mem_wr;
    word_addr_t count;
    word_addr_t pc;
    word_addr_t fetch_addr;
    word_addr_t data_addr;
    word_t      instr;
    word_t      read_data;
    logic       cpu_rst_n;

    // CPU sits in reset for the whole load
    assign cpu_rst_n = sysrst && !load_en;
    assign mem_wr    = load_en ? load_wr : cpu_wr;

    // pc has moved past HALT, so fetch trails by one to keep the halt word shown
    assign fetch_addr = halted ? pc - 1'b1 : pc;

    uart_rx uart_rx_i (
        .sysclk     (sysclk),
        .sysrst     (sysrst),
        .rx         (rx),
        .byte_valid (byte_valid),
        .byte_data  (byte_data)
    );

    uart_word_assembler uart_word_assembler_i (
        .sysclk     (sysclk),
        .sysrst     (sysrst),
        .load_en    (load_en),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .word_valid (word_valid),
        .word_data  (word_data)
    );

    program_loader program_loader_i (
        .sysclk     (sysclk),
        .sysrst     (sysrst),
        .load_en    (load_en),
        .word_valid (word_valid),
        .word_data  (word_data),
        .load_wr    (load_wr),
        .count      (count)
    );

    memory_map memory_map_i (
        .sysclk     (sysclk),
        .sysrst     (sysrst),
        .wr         (mem_wr),
        .pc         (fetch_addr),
        .data_addr  (data_addr),
        .instr      (instr),
        .read_data  (read_data),
        .leds       (leds)
    );

    tiny_cpu tiny_cpu_i (
        .sysclk     (sysclk),
        .rst_n      (cpu_rst_n),
        .instr      (instr),
        .read_data  (read_data),
        .pc         (pc),
        .data_addr  (data_addr),
        .cpu_wr     (cpu_wr),
        .halted     (halted)
    );

    hex_display hex_display_i (
        .load_en    (load_en),
        .debug_mode (debug_mode),
        .instr      (instr),
        .pc         (pc),
        .count      (count),
        .leds       (leds),
        .hex        (hex)
    );

endmodule

// File: hex_display.sv
`timescale 1ns/1ps

module hex_display import little_computer_pkg::*; (
    input  logic                      load_en,
    input  logic                      debug_mode,
    input  word_t                     instr,
    input  word_addr_t                pc,
    input  word_addr_t                count,
    input  led_t                      leds,
    output logic [8*num_digits-1:0]   hex
);

    logic [4*num_digits-1:0] value;

    always_comb begin
        if (load_en) begin
            value = (4 * num_digits)'(count);
        end else if (debug_mode) begin
            value = {instr, pc};
        end else begin
            value = (4 * num_digits)'(leds);
        end
    end

    // Digit 0 is the rightmost one, in the low bits
    always_comb begin
        for (int i = 0; i < num_digits; i++) begin
            hex[8*i +: 8] = seg_encode(value[4*i +: 4]);
        end
    end

endmodule

// File: tiny_cpu.sv
`timescale 1ns/1ps

module tiny_cpu import little_computer_pkg::*; (
    input  logic       sysclk,
    input  logic       rst_n,
    input  word_t      instr,
    input  word_t      read_data,
    output word_addr_t pc,
    output word_addr_t data_addr,
    output mem_wr_t    cpu_wr,
    output logic       halted
);

    cpu_state_e state;
    word_t      regs [4];
    opcode_e    op;
    reg_idx_t   rd;
    reg_idx_t   rs;
    byte_t      imm;
    reg_idx_t   mem_rd;
    logic       mem_load;

    assign op  = opcode_e'(instr[15:12]);
    assign rd  = instr[11:10];
    assign rs  = instr[9:8];
    assign imm = instr[7:0];

    // Presented during EXEC so read data is ready in MEM_WAIT
    assign data_addr = regs[rs][7:0];
    assign halted    = (state == HALTED);

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            state    <= RESET_WAIT;
            pc       <= '0;
            regs     <= '{default: '0};
            cpu_wr   <= '0;
            mem_rd   <= '0;
            mem_load <= 1'b0;
        end else begin
            cpu_wr.en <= 1'b0;
            case (state)
                RESET_WAIT: state <= FETCH;
                FETCH:      state <= EXEC;
                EXEC: begin
                    pc    <= pc + 1'b1;
                    state <= FETCH;
                    case (op)
                        LDI: regs[rd] <= word_t'(imm);
                        ADD: regs[rd] <= regs[rd] + regs[rs];
                        LW: begin
                            mem_rd   <= rd;
                            mem_load <= 1'b1;
                            state    <= MEM_WAIT;
                        end
                        SW: begin
                            cpu_wr.en   <= 1'b1;
                            cpu_wr.addr <= data_addr;
                            cpu_wr.data <= regs[rd];
                            mem_load    <= 1'b0;
                            state       <= MEM_WAIT;
                        end
                        JMP: pc <= imm;
                        BEQZ: begin
                            if (regs[rd] == '0) begin
                                pc <= imm;
                            end
                        end
                        HALT: state <= HALTED;
                        // Unused codes fall through as NOP
                        default: ;
                    endcase
                end
                MEM_WAIT: begin
                    // Store completes on this edge, load data is on read_data
                    if (mem_load) begin
                        regs[mem_rd] <= read_data;
                    end
                    state <= FETCH;
                end
                HALTED: state <= HALTED;
                default: state <= RESET_WAIT;
            endcase
        end
    end

endmodule

// File: memory_map.sv
`timescale 1ns/1ps

module memory_map import little_computer_pkg::*; (
    input  logic       sysclk,
    input  logic       sysrst,
    input  mem_wr_t    wr,
    input  word_addr_t pc,
    input  word_addr_t data_addr,
    output word_t      instr,
    output word_t      read_data,
    output led_t       leds
);

    word_t ram [256];
    logic  wr_led;

    assign wr_led = wr.en && (wr.addr == led_addr);

    // LED address is not backed by RAM
    always_ff @(posedge sysclk) begin
        if (wr.en && !wr_led) begin
            ram[wr.addr] <= wr.data;
        end
        instr <= ram[pc];
        if (data_addr == led_addr) begin
            read_data <= word_t'(leds);
        end else begin
            read_data <= ram[data_addr];
        end
    end

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            leds <= '0;
        end else if (wr_led) begin
            leds <= wr.data[9:0];
        end
    end

endmodule

// File: program_loader.sv
`timescale 1ns/1ps

module program_loader import little_computer_pkg::*; (
    input  logic       sysclk,
    input  logic       sysrst,
    input  logic       load_en,
    input  logic       word_valid,
    input  word_t      word_data,
    output mem_wr_t    load_wr,
    output word_addr_t count
);

    logic load_en_q;
    logic load_rise;

    assign load_rise = load_en && !load_en_q;

    // Each word lands at the address given by the running count
    always_comb begin
        load_wr.en   = word_valid && load_en;
        load_wr.addr = count;
        load_wr.data = word_data;
    end

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            load_en_q <= 1'b0;
        end else begin
            load_en_q <= load_en;
        end
    end

    // Wraps after 256 words
    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            count <= '0;
        end else if (load_rise) begin
            count <= '0;
        end else if (load_wr.en) begin
            count <= count + 1'b1;
        end
    end

endmodule

// File: uart_word_assembler.sv
`timescale 1ns/1ps

module uart_word_assembler import little_computer_pkg::*; (
    input  logic  sysclk,
    input  logic  sysrst,
    input  logic  load_en,
    input  logic  byte_valid,
    input  byte_t byte_data,
    output logic  word_valid,
    output word_t word_data
);

    // Set while the high byte is held and the low byte is awaited
    logic  phase;
    byte_t hi_byte;

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            phase      <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= 1'b0;
            if (!load_en) begin
                phase <= 1'b0;
            end else if (byte_valid) begin
                phase      <= !phase;
                word_valid <= phase;
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (load_en && byte_valid) begin
            if (!phase) begin
                hi_byte <= byte_data;
            end else begin
                word_data <= {hi_byte, byte_data};
            end
        end
    end

endmodule

// File: uart_rx.sv
`timescale 1ns/1ps

module uart_rx import little_computer_pkg::*; (
    input  logic  sysclk,
    input  logic  sysrst,
    input  logic  rx,
    output logic  byte_valid,
    output byte_t byte_data
);

    logic [1:0]  rx_sync;
    logic        rx_s;
    uart_state_e state;
    logic [4:0]  clk_cnt;
    logic [2:0]  bit_idx;
    logic        frame_err;
    logic        bit_end;
    logic        half_bit;

    assign rx_s     = rx_sync[1];
    assign bit_end  = (clk_cnt == clks_per_bit - 1);
    assign half_bit = (clk_cnt == clks_per_bit / 2 - 1);

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            // Line idles high
            rx_sync    <= 2'b11;
            state      <= IDLE;
            clk_cnt    <= '0;
            bit_idx    <= '0;
            frame_err  <= 1'b0;
            byte_valid <= 1'b0;
        end else begin
            rx_sync    <= {rx_sync[0], rx};
            byte_valid <= 1'b0;
            case (state)
                IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_s) begin
                        state <= START;
                    end
                end
                START: begin
                    if (half_bit) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        // Glitch on the line, not a real start bit
                        state   <= rx_s ? IDLE : DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                STOP: begin
                    if (!bit_end) begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end else if (rx_s) begin
                        byte_valid <= !frame_err;
                        frame_err  <= 1'b0;
                        state      <= IDLE;
                    end else begin
                        // Bad stop bit, hold here until the line returns high
                        frame_err <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge sysclk) begin
        if (state == DATA && bit_end) begin
            byte_data <= {rx_s, byte_data[7:1]};
        end
    end

endmodule

// File: little_computer_pkg.sv
package little_computer_pkg;

    typedef logic [15:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  word_addr_t;
    typedef logic [1:0]  reg_idx_t;
    typedef logic [9:0]  led_t;

    // Instruction layout: op[15:12] rd[11:10] rs[9:8] imm8[7:0]
    typedef enum logic [3:0] {
        NOP  = 4'h0,
        LDI  = 4'h1,
        ADD  = 4'h2,
        LW   = 4'h3,
        SW   = 4'h4,
        JMP  = 4'h5,
        BEQZ = 4'h6,
        HALT = 4'hF
    } opcode_e;

    typedef enum logic [2:0] {
        RESET_WAIT,
        FETCH,
        EXEC,
        MEM_WAIT,
        HALTED
    } cpu_state_e;

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } uart_state_e;

    typedef struct packed {
        logic       en;
        word_addr_t addr;
        word_t      data;
    } mem_wr_t;

    localparam int         clks_per_bit = 16;
    localparam word_addr_t led_addr     = 8'hFF;
    localparam int         num_digits   = 6;

    // Active-low segments, bit 7 is the decimal point and stays dark
    function automatic logic [7:0] seg_encode(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 8'hC0;
            4'h1: return 8'hF9;
            4'h2: return 8'hA4;
            4'h3: return 8'hB0;
            4'h4: return 8'h99;
            4'h5: return 8'h92;
            4'h6: return 8'h82;
            4'h7: return 8'hF8;
            4'h8: return 8'h80;
            4'h9: return 8'h90;
            4'hA: return 8'h88;
            4'hB: return 8'h83;
            4'hC: return 8'hC6;
            4'hD: return 8'hA1;
            4'hE: return 8'h86;
            default: return 8'h8E;
        endcase
    endfunction

endpackage
